// ==== block_compare/block_compare_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// block compare subsystem top
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module block_compare_top (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic [7:0]               source,
    input  block_cmp_pkg::cpu_regs_t init_regs,
    input  logic                     wb_ack,
    input  logic [7:0]               wb_dat_r,
    output logic                     busy,
    output logic                     done,
    output block_cmp_pkg::cpu_regs_t result,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic                     wb_we,
    output logic                     wb_sel,
    output logic [15:0]              wb_adr
);
    import block_cmp_pkg::*;

    xpt_t       xpt;
    cp_ctrl_t   ctrl;
    cpu_regs_t  regs;
    logic [7:0] op_q;
    logic [7:0] rd_data;
    logic       rd_done;
    logic       cmp_zero;
    logic       bc_zero;

    xpt_sequencer i_xpt_sequencer (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .source   (source),
        .rd_done  (rd_done),
        .cmp_zero (cmp_zero),
        .bc_zero  (bc_zero),
        .xpt      (xpt),
        .op_q     (op_q),
        .busy     (busy),
        .done     (done)
    );

    cp_block_decoder i_cp_block_decoder (
        .xpt    (xpt),
        .source (op_q),   // latched opcode
        .ctrl   (ctrl)
    );

    block_datapath i_block_datapath (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .init_regs (init_regs),
        .ctrl      (ctrl),
        .rd_data   (rd_data),
        .regs      (regs),
        .cmp_zero  (cmp_zero),
        .bc_zero   (bc_zero)
    );

    wb_read_master i_wb_read_master (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .addr     (regs.hl),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_sel   (wb_sel),
        .wb_adr   (wb_adr),
        .rd_done  (rd_done),
        .rd_data  (rd_data)
    );

    assign result = regs;

endmodule

// ==== block_compare/block_datapath.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// register file, add/sub unit and flags
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module block_datapath (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  block_cmp_pkg::cpu_regs_t init_regs,
    input  block_cmp_pkg::cp_ctrl_t  ctrl,
    input  logic [7:0]               rd_data,
    output block_cmp_pkg::cpu_regs_t regs,
    output logic                     cmp_zero,
    output logic                     bc_zero
);
    import block_cmp_pkg::*;

    cpu_regs_t   r;
    logic [7:0]  dt;
    logic [15:0] opnd_x;
    logic [15:0] opnd_y;
    logic [15:0] alu_out;
    logic        idle;
    logic        half_borrow;

    // no strobe active means between instructions
    assign idle = (ctrl == '0);

    always_comb begin
        if (ctrl.pa_select_a_high) begin
            opnd_x = {8'h00, r.a};
        end else if (ctrl.pa_select_bc_high) begin
            opnd_x = r.bc;
        end else if (ctrl.pa_select_hl_high) begin
            opnd_x = r.hl;
        end else begin
            opnd_x = 16'h0000;
        end
    end

    always_comb begin
        if (ctrl.pa_select_dt_low) begin
            opnd_y = {8'h00, dt};
        end else if (ctrl.pa_select_0x1_low) begin
            opnd_y = 16'h0001;
        end else begin
            opnd_y = 16'h0000;
        end
    end

    always_comb begin
        if (ctrl.pa_sub) begin
            alu_out = opnd_x - opnd_y;
        end else if (ctrl.pa_add) begin
            alu_out = opnd_x + opnd_y;
        end else begin
            alu_out = opnd_x;
        end
    end

    // borrow into bit 4 of A - Dt
    assign half_borrow = opnd_x[4] ^ opnd_y[4] ^ alu_out[4];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            r <= '0;
        end else if (start && idle) begin
            r <= init_regs;
        end else begin
            if (ctrl.pr_write_b) begin
                r.bc[15:8] <= alu_out[15:8];
            end
            if (ctrl.pr_write_c) begin
                r.bc[7:0] <= alu_out[7:0];
            end
            if (ctrl.pr_write_h) begin
                r.hl[15:8] <= alu_out[15:8];
            end
            if (ctrl.pr_write_l) begin
                r.hl[7:0] <= alu_out[7:0];
            end
            if (ctrl.pf_write_s) begin
                r.f[flag_idx_s] <= alu_out[7];
            end
            if (ctrl.pf_write_z) begin
                r.f[flag_idx_z] <= (alu_out[7:0] == 8'h00);
            end
            if (ctrl.pf_write_h) begin
                r.f[flag_idx_h] <= half_borrow;
            end
            if (ctrl.pf_write_pv) begin
                r.f[flag_idx_pv] <= (alu_out != 16'h0000);  // new BC
            end
            if (ctrl.pf_write_n) begin
                r.f[flag_idx_n] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.pr_write_dt && ctrl.pc_r2) begin
            dt <= rd_data;
        end
    end

    assign regs     = r;
    assign cmp_zero = r.f[flag_idx_z];
    assign bc_zero  = (r.bc == 16'h0000);

endmodule

// ==== block_compare/cp_block_decoder.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// control strobe decoder, CPI/CPIR/CPD/CPDR
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module cp_block_decoder (
    input  block_cmp_pkg::xpt_t     xpt,
    input  logic [7:0]              source,
    output block_cmp_pkg::cp_ctrl_t ctrl
);
    import block_cmp_pkg::*;

    logic [4:0] t;
    logic       t01xx;
    logic       t10xx;
    logic       t100x;
    logic [9:4] dec;
    logic       t4_6;

    assign t = xpt;

    // upper bits first, then the low pair
    assign t01xx = ~t[4] & (t[3:2] == 2'b01);
    assign t10xx = ~t[4] & (t[3:2] == 2'b10);

    assign dec[4] = t01xx & (t[1:0] == 2'b00);
    assign dec[5] = t01xx & (t[1:0] == 2'b01);
    assign dec[6] = t01xx & (t[1:0] == 2'b10);
    assign dec[7] = t01xx & (t[1:0] == 2'b11);

    assign t100x  = t10xx & ~t[1];  // 8 or 9
    assign dec[8] = t100x & ~t[0];
    assign dec[9] = t100x & t[0];

    assign t4_6 = t01xx & ~dec[7];

    // 4..6 memory read at HL
    assign ctrl.pc_r0           = dec[4];
    assign ctrl.pc_r1           = dec[5];
    assign ctrl.pc_r2           = dec[6];
    assign ctrl.pi_select_ad_hl = t4_6;
    assign ctrl.pr_write_dt     = dec[6];

    // 7 compare A with Dt
    assign ctrl.pa_select_a_high = dec[7];
    assign ctrl.pa_select_dt_low = dec[7];
    assign ctrl.pf_write_z       = dec[7];
    assign ctrl.pf_write_s       = dec[7];
    assign ctrl.pf_write_h       = dec[7];

    // 8 BC - 1
    assign ctrl.pa_select_bc_high = dec[8];
    assign ctrl.pr_write_b        = dec[8];
    assign ctrl.pr_write_c        = dec[8];
    assign ctrl.pf_write_pv       = dec[8];

    assign ctrl.pa_select_0x1_low = t100x;

    // 9 HL +/- 1, direction from opcode bit 3
    assign ctrl.pa_select_hl_high = dec[9];
    assign ctrl.pr_write_h        = dec[9];
    assign ctrl.pr_write_l        = dec[9];
    assign ctrl.pf_write_n        = dec[9];

    assign ctrl.pa_add = dec[9] & ~source[op_bit_dec];
    assign ctrl.pa_sub = (dec[9] & source[op_bit_dec]) | dec[7] | dec[8];

endmodule

// ==== block_compare/xpt_sequencer.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// T-state sequencer for CPI/CPD/CPIR/CPDR
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module xpt_sequencer (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    input  logic [7:0]         source,
    input  logic               rd_done,
    input  logic               cmp_zero,
    input  logic               bc_zero,
    output block_cmp_pkg::xpt_t xpt,
    output logic [7:0]         op_q,
    output logic               busy,
    output logic               done
);
    import block_cmp_pkg::*;

    xpt_t xpt_q;
    logic repeat_go;

    // repeat while BC left and no match yet
    assign repeat_go = op_q[op_bit_rep] && !bc_zero && !cmp_zero;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xpt_q <= XPT_IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (xpt_q)
                XPT_IDLE: begin
                    if (start) begin
                        xpt_q <= XPT_4;
                    end
                end
                XPT_4: begin
                    if (rd_done) begin   // stretched by the bus
                        xpt_q <= XPT_5;
                    end
                end
                XPT_5: xpt_q <= XPT_6;
                XPT_6: xpt_q <= XPT_7;
                XPT_7: xpt_q <= XPT_8;
                XPT_8: xpt_q <= XPT_9;
                XPT_9: begin
                    if (repeat_go) begin
                        xpt_q <= XPT_4;
                    end else begin
                        xpt_q <= XPT_IDLE;
                        done  <= 1'b1;
                    end
                end
                default: xpt_q <= XPT_IDLE;
            endcase
        end
    end

    // opcode held for the whole instruction
    always_ff @(posedge clk) begin
        if (start && xpt_q == XPT_IDLE) begin
            op_q <= source;
        end
    end

    assign xpt  = xpt_q;
    assign busy = (xpt_q != XPT_IDLE);

endmodule

// ==== common/block_cmp_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// types and constants for the Z80 block compare group
// ~~~~~~~~~~~~~~~~~~~~
package block_cmp_pkg;

    // T-state number, same coding as the CPU XPT counter
    typedef enum logic [4:0] {
        XPT_IDLE = 5'd0,
        XPT_4    = 5'd4,
        XPT_5    = 5'd5,
        XPT_6    = 5'd6,
        XPT_7    = 5'd7,
        XPT_8    = 5'd8,
        XPT_9    = 5'd9
    } xpt_t;

    typedef struct packed {
        logic pc_r0;             // read cycle, address phase
        logic pc_r1;
        logic pc_r2;             // read cycle, data phase
        logic pi_select_ad_hl;
        logic pr_write_dt;
        logic pr_write_b;
        logic pr_write_c;
        logic pr_write_h;
        logic pr_write_l;
        logic pa_select_a_high;
        logic pa_select_dt_low;
        logic pa_select_bc_high;
        logic pa_select_hl_high;
        logic pa_select_0x1_low;
        logic pa_add;
        logic pa_sub;
        logic pf_write_z;
        logic pf_write_s;
        logic pf_write_h;
        logic pf_write_pv;
        logic pf_write_n;
    } cp_ctrl_t;

    typedef struct packed {
        logic [7:0]  a;
        logic [7:0]  f;
        logic [15:0] bc;
        logic [15:0] hl;
    } cpu_regs_t;

    // bit positions in F
    localparam int flag_idx_s  = 7;
    localparam int flag_idx_z  = 6;
    localparam int flag_idx_h  = 4;
    localparam int flag_idx_pv = 2;
    localparam int flag_idx_n  = 1;
    localparam int flag_idx_c  = 0;

    // second opcode byte fields, 101x_x001
    localparam int op_bit_dec = 3;  // CPD / CPDR
    localparam int op_bit_rep = 4;  // CPIR / CPDR

endpackage

// ==== filelist.f ====
common/block_cmp_pkg.sv
logic/wb_read_master.sv
block_compare/xpt_sequencer.sv
block_compare/cp_block_decoder.sv
block_compare/block_datapath.sv
block_compare/block_compare_top.sv
tests/block_compare_assert.sv
tests/block_compare_checker.sv
tests/tb_block_compare.sv

// ==== logic/wb_read_master.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Wishbone classic single-read master
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module wb_read_master (
    input  logic                    clk,
    input  logic                    rst_n,
    input  block_cmp_pkg::cp_ctrl_t ctrl,
    input  logic [15:0]             addr,
    input  logic                    wb_ack,
    input  logic [7:0]              wb_dat_r,
    output logic                    wb_cyc,
    output logic                    wb_stb,
    output logic                    wb_we,
    output logic                    wb_sel,
    output logic [15:0]             wb_adr,
    output logic                    rd_done,
    output logic [7:0]              rd_data
);
    import block_cmp_pkg::*;

    logic       ack_q;
    logic [7:0] data_q;

    // cycle open from first T4 until the ack is seen
    assign wb_cyc = ctrl.pc_r0 & ~ack_q;
    assign wb_stb = wb_cyc;
    assign wb_we  = 1'b0;
    assign wb_sel = wb_cyc;
    assign wb_adr = ctrl.pi_select_ad_hl ? addr : 16'h0000;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= wb_cyc & wb_ack;
        end
    end

    always_ff @(posedge clk) begin
        if (wb_cyc && wb_ack) begin
            data_q <= wb_dat_r;
        end
    end

    assign rd_done = ack_q;
    assign rd_data = data_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the block compare testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_block_compare \
    -f filelist.f

./obj_dir/Vtb_block_compare 2>&1 | tee sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "No errors" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"

// ==== tests/block_compare_assert.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// Wishbone read assertions, bound into wb_read_master
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module block_compare_assert (
    input logic        clk,
    input logic        rst_n,
    input logic        wb_cyc,
    input logic        wb_stb,
    input logic        wb_we,
    input logic [15:0] wb_adr,
    input logic        wb_ack,
    input logic        rd_done
);

    // request and address held until the slave answers
    stb_held: assert property (@(posedge clk) disable iff (!rst_n)
        (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
        else $error("wb_stb or wb_adr changed before wb_ack");

    no_write: assert property (@(posedge clk) disable iff (!rst_n) !wb_we)
        else $error("wb_we driven high on a read-only port");

    // sequencer must leave T4 once the read is done
    done_closes_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        rd_done |=> !wb_cyc)
        else $error("bus cycle reopened right after the read completed");

endmodule

bind wb_read_master block_compare_assert i_block_compare_assert (
    .clk     (clk),
    .rst_n   (rst_n),
    .wb_cyc  (wb_cyc),
    .wb_stb  (wb_stb),
    .wb_we   (wb_we),
    .wb_adr  (wb_adr),
    .wb_ack  (wb_ack),
    .rd_done (rd_done)
);

// ==== tests/block_compare_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// result checker with reference model of CPI/CPD/CPIR/CPDR
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module block_compare_checker (
    input logic                     clk,
    input logic                     rst_n,
    input logic                     start,
    input logic                     busy,
    input logic                     done,
    input logic                     wb_stb,
    input logic                     wb_sel,
    input logic [7:0]               source,
    input block_cmp_pkg::cpu_regs_t init_regs,
    input block_cmp_pkg::cpu_regs_t result
);
    import block_cmp_pkg::*;

    localparam logic [7:0] keep_mask = 8'h29;  // bits 5, 3 and C

    int         err_count = 0;
    int         test_count = 0;
    int         errs;
    int         run_errs = 0;
    logic       pending = 1'b0;
    logic [7:0] op_q;
    cpu_regs_t  init_q;
    cpu_regs_t  exp_r;

    // memory contents seen by the bus slave
    function automatic logic [7:0] bus_byte(input logic [15:0] adr);
        return (adr[7:0] ^ adr[15:8]) + 8'h35;
    endfunction

    function automatic cpu_regs_t ref_block_cmp(input logic [7:0] op, input cpu_regs_t in);
        cpu_regs_t  r;
        logic [7:0] m;
        logic [7:0] d;
        logic       stop;
        r    = in;
        stop = 1'b0;
        while (!stop) begin
            m = bus_byte(r.hl);
            d = r.a - m;
            r.f[flag_idx_s]  = d[7];
            r.f[flag_idx_z]  = (d == 8'h00);
            r.f[flag_idx_h]  = (r.a[3:0] < m[3:0]);  // borrow from bit 4
            r.bc             = r.bc - 16'd1;
            r.f[flag_idx_pv] = (r.bc != 16'h0000);
            r.f[flag_idx_n]  = 1'b1;
            r.hl = op[op_bit_dec] ? r.hl - 16'd1 : r.hl + 16'd1;
            if (!op[op_bit_rep] || r.bc == 16'h0000 || d == 8'h00) begin
                stop = 1'b1;
            end
        end
        return r;
    endfunction

    function automatic int check_field(input string name, input logic [15:0] got,
                                       input logic [15:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
            return 1;
        end
        return 0;
    endfunction

    always @(negedge clk) begin
        if (!rst_n) begin
            pending = 1'b0;
        end else begin
            // busy from the cycle after start up to done
            if (busy !== (pending && !done)) begin
                $display("Mismatch busy: got %h, expected %h", busy, pending && !done);
                err_count++;
                run_errs++;
            end
            if (wb_stb && wb_sel !== 1'b1) begin
                $display("Mismatch wb_sel: got %h, expected %h", wb_sel, 1'b1);
                err_count++;
                run_errs++;
            end
            if (done) begin
                if (!pending) begin
                    $display("done pulse arrived without a pending request");
                    err_count++;
                end else begin
                    exp_r = ref_block_cmp(op_q, init_q);
                    errs  = 0;
                    errs += check_field("result.a", {8'h00, result.a}, {8'h00, exp_r.a});
                    errs += check_field("result.f", {8'h00, result.f}, {8'h00, exp_r.f});
                    errs += check_field("result.bc", result.bc, exp_r.bc);
                    errs += check_field("result.hl", result.hl, exp_r.hl);
                    errs += check_field("result.f kept bits", {8'h00, result.f & keep_mask},
                                        {8'h00, init_q.f & keep_mask});
                    test_count++;
                    err_count += errs;
                    if (errs + run_errs == 0) begin
                        $display("test %0d source %h: pass", test_count, op_q);
                    end else begin
                        $display("test %0d source %h: FAIL, %0d mismatches",
                                 test_count, op_q, errs + run_errs);
                    end
                end
                pending  = 1'b0;
                run_errs = 0;
            end
            if (start && !busy) begin  // request accepted at next edge
                op_q    = source;
                init_q  = init_regs;
                pending = 1'b1;
            end
        end
    end

endmodule

// ==== tests/tb_block_compare.sv ====
// ~~~~~~~~~~~~~~~~~~~~
// testbench top: clock, reset, stimulus, memory model, watchdog
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_block_compare;
    import block_cmp_pkg::*;

    localparam int clk_period   = 100;
    localparam int reset_cycles = 4;
    localparam int num_directed = 4;
    localparam int num_random   = 8;
    localparam int num_tests    = num_directed + num_random;
    localparam int max_bc       = 16;
    localparam int iter_cycles  = 10;  // T4 with 3 waits, then 5..9
    localparam int watchdog_cycles = reset_cycles + num_tests * (max_bc * iter_cycles + 4);

    logic        clk;
    logic        rst_n;
    logic        start;
    logic [7:0]  source;
    cpu_regs_t   init_regs;
    logic        wb_ack;
    logic [7:0]  wb_dat_r;
    logic        busy;
    logic        done;
    cpu_regs_t   result;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic        wb_sel;
    logic [15:0] wb_adr;
    logic [31:0] lfsr_q;

    block_compare_top i_block_compare_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .source    (source),
        .init_regs (init_regs),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r),
        .busy      (busy),
        .done      (done),
        .result    (result),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_sel    (wb_sel),
        .wb_adr    (wb_adr)
    );

    block_compare_checker i_block_compare_checker (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .busy      (busy),
        .done      (done),
        .wb_stb    (wb_stb),
        .wb_sel    (wb_sel),
        .source    (source),
        .init_regs (init_regs),
        .result    (result)
    );

    // Galois form, taps 32,22,2,1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v      = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    function automatic logic [7:0] mem_byte(input logic [15:0] adr);
        return (adr[7:0] ^ adr[15:8]) + 8'h35;
    endfunction

    function automatic cpu_regs_t make_regs(input logic [7:0] a, input logic [7:0] f,
                                            input logic [15:0] bc, input logic [15:0] hl);
        cpu_regs_t r;
        r.a  = a;
        r.f  = f;
        r.bc = bc;
        r.hl = hl;
        return r;
    endfunction

    // Wishbone slave, 0 to 3 wait cycles per read
    task automatic serve_reads();
        logic [31:0] w;
        int          wait_left;
        logic        in_req;
        in_req    = 1'b0;
        wait_left = 0;
        forever begin
            @(posedge clk);
            #10;
            if (wb_ack) begin
                wb_ack = 1'b0;
                in_req = 1'b0;
            end else if (rst_n && wb_cyc && wb_stb) begin
                if (!in_req) begin
                    in_req = 1'b1;
                    draw_bits(2, w);
                    wait_left = int'(w[1:0]);
                end
                if (wait_left == 0) begin
                    wb_ack   = 1'b1;
                    wb_dat_r = mem_byte(wb_adr);
                end else begin
                    wait_left--;
                end
            end
        end
    endtask

    task automatic run_op(input logic [7:0] op, input cpu_regs_t regs_in);
        start     = 1'b1;
        source    = op;
        init_regs = regs_in;
        @(posedge clk);
        #10;
        start = 1'b0;
        while (!done) begin
            @(posedge clk);
            #10;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    initial begin
        logic [31:0] v;
        logic [7:0]  op;
        logic [7:0]  a;
        logic [15:0] hl;
        logic [15:0] bc;
        logic [15:0] off;
        int          total_errs;
        rst_n     = 1'b0;
        start     = 1'b0;
        source    = 8'h00;
        init_regs = '0;
        wb_ack    = 1'b0;
        wb_dat_r  = 8'h00;
        lfsr_q    = 32'h7979_76b6;
        fork
            serve_reads();
        join_none
        repeat (reset_cycles) @(posedge clk);
        #10;
        rst_n = 1'b1;
        @(posedge clk);
        #10;

        run_op(8'hA1, make_regs(8'h10, 8'h00, 16'h0005, 16'h1234));  // CPI, byte 5b
        run_op(8'hA9, make_regs(8'h95, 8'h29, 16'h0001, 16'h2040));  // CPD, byte 95 hits
        run_op(8'hB1, make_regs(8'h35, 8'h00, 16'h000a, 16'h0300));  // CPIR, hit at 0303
        run_op(8'hB9, make_regs(8'h00, 8'h01, 16'h000c, 16'h5000));  // CPDR, no hit

        for (int t = 0; t < num_random; t++) begin
            draw_bits(2, v);
            op = 8'hA1 | {3'b000, v[1:0], 3'b000};
            draw_bits(16, v);
            hl = v[15:0];
            draw_bits(4, v);
            bc = {12'h000, v[3:0]};
            if (t == 0 || bc == 16'h0000) begin
                bc = 16'h0001;
            end
            draw_bits(4, v);
            off = {13'h0000, v[2:0]};
            if (v[3]) begin
                a = mem_byte(op[op_bit_dec] ? hl - off : hl + off);  // plant a match
            end else begin
                draw_bits(8, v);
                a = v[7:0];
            end
            draw_bits(8, v);
            run_op(op, make_regs(a, v[7:0], bc, hl));
        end

        repeat (2) @(posedge clk);
        total_errs = i_block_compare_checker.err_count;
        if (i_block_compare_checker.test_count != num_tests) begin
            $display("checker saw %0d results for %0d tests",
                     i_block_compare_checker.test_count, num_tests);
            total_errs++;
        end
        $display("tests: %0d, errors: %0d", num_tests, total_errs);
        if (total_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("Timeout: tests did not finish within %0d clock cycles", watchdog_cycles);
        $display("Errors found");
        $finish;
    end

endmodule
